/* reduce_config.svh */
// ==========================================================================
// build-time shape and sizing of the tile reduction engine
// one tile shape per build, elements are DW-bit two's complement
// BUF_DEPTH must be a power of two, the ring pointers wrap on it
// ==========================================================================
`ifndef REDUCE_CONFIG_SVH
`define REDUCE_CONFIG_SVH

// element width in bits
`define DW          16

// tile shape h*p*n, reduction runs over n
`define H_TILE      1
`define P_TILE      2
`define N_TILE      8

// tile slots in the buffer, equals host credits after reset
`define BUF_DEPTH   4
// result credits held by the engine after reset
`define OUT_CREDITS 2

`endif

/* reduce_pkg.sv */
// ==========================================================================
// shared types of the tile reduction engine
// widths come from the build-time macros, nothing here is run-time sized
// ==========================================================================
`include "reduce_config.svh"

package reduce_pkg;

  // ========================================================================
  // data vectors
  // ========================================================================

  // one element, adds wrap modulo 2^DW
  typedef logic [`DW-1:0] elem_t;

  // whole tile, element (h,p,n) at flat index ((h*P+p)*N+n), lsb slice first
  typedef logic [`H_TILE*`P_TILE*`N_TILE*`DW-1:0] tile_t;

  // one sum per (h,p) lane, same lane order as the tile
  typedef logic [`H_TILE*`P_TILE*`DW-1:0] result_t;

  // ring slot index
  typedef logic [$clog2(`BUF_DEPTH)-1:0] slot_t;

  // ========================================================================
  // control
  // ========================================================================

  // drain issues one read, then waits while the data comes back
  typedef enum logic [0:0] {
    DRAIN_IDLE,
    DRAIN_READ
  } drain_state_e;

  // adder tree depth, also the tree latency in cycles
  localparam int STAGES = $clog2(`N_TILE);

endpackage

/* tile_mem_if.sv */
// ==========================================================================
// one requester's port onto the shared tile memory
// access happens when req and gnt are both high, rdata valid a cycle later
// ==========================================================================
`timescale 1ns/100ps

interface tile_mem_if import reduce_pkg::*; ();

  // request side
  logic  req;
  // 1 for write, 0 for read
  logic  we;
  slot_t addr;
  tile_t wdata;

  // answer side, gnt is combinational
  logic  gnt;
  // registered read data
  tile_t rdata;

  // used by ingest, drain, and the arbiter toward the buffer
  modport requester (
    output req, we, addr, wdata,
    input  gnt, rdata
  );

  // used by the arbiter toward its peers, and by the buffer
  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rdata
  );

endinterface

/* tile_buffer.sv */
// ==========================================================================
// single-port tile store, one access per cycle
// every request is accepted, read data is registered
// contents are undefined until written
// ==========================================================================
`timescale 1ns/100ps
`include "reduce_config.svh"

module tile_buffer import reduce_pkg::*; (
  input logic         clk,
  tile_mem_if.arbiter mem
);

  // one tile per slot
  tile_t slots_q [`BUF_DEPTH];

  // single port never stalls a request
  assign mem.gnt = mem.req;

  // write on a granted write, register read data on a granted read
  always_ff @(posedge clk) begin
    if (mem.req && mem.gnt) begin
      if (mem.we) begin
        slots_q[mem.addr] <= mem.wdata;
      end else begin
        mem.rdata <= slots_q[mem.addr];
      end
    end
  end

  // ========================================================================
  // checks
  // ========================================================================

  // the winning requester must present a known in-range slot
  a_addr_in_range: assert property (
    @(posedge clk)
    mem.req |-> (!$isunknown(mem.addr) && (int'(mem.addr) < `BUF_DEPTH))
  ) else $error("tile_buffer: bad slot address %0d", mem.addr);

endmodule

/* mem_arbiter.sv */
// ==========================================================================
// fixed-priority arbiter in front of the tile buffer
// writer always wins, reader only gets an idle cycle
// reader starvation is bounded by host credits, not by this block
// ==========================================================================
`timescale 1ns/100ps

module mem_arbiter import reduce_pkg::*; (
  input logic           clk,
  input logic           rst_n_i,
  tile_mem_if.arbiter   wr_port,
  tile_mem_if.arbiter   rd_port,
  tile_mem_if.requester mem
);

  logic wr_win;

  // write port has priority whenever it asks
  assign wr_win = wr_port.req;

  // ========================================================================
  // request path toward the buffer
  // ========================================================================

  assign mem.req   = wr_port.req | rd_port.req;
  // steer the winner's fields onto the single port
  assign mem.we    = wr_win ? wr_port.we    : rd_port.we;
  assign mem.addr  = wr_win ? wr_port.addr  : rd_port.addr;
  assign mem.wdata = wr_win ? wr_port.wdata : rd_port.wdata;

  // ========================================================================
  // answer path toward the peers
  // ========================================================================

  // grants follow the buffer's acceptance
  assign wr_port.gnt = wr_port.req & mem.gnt;
  assign rd_port.gnt = rd_port.req & ~wr_port.req & mem.gnt;

  // read data is broadcast, only the reader uses it
  assign wr_port.rdata = mem.rdata;
  assign rd_port.rdata = mem.rdata;

  // never two owners of the single port
  a_one_grant: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    !(wr_port.gnt && rd_port.gnt)
  ) else $error("mem_arbiter: write and read granted together");

endmodule

/* tile_ingest.sv */
// ==========================================================================
// host side of the engine, one tile per cycle at most
// host must hold a credit before raising tile_valid_i
// a tile is written one edge after it is sampled, it has write priority
// ==========================================================================
`timescale 1ns/100ps
`include "reduce_config.svh"

module tile_ingest import reduce_pkg::*; (
  input  logic          clk,
  input  logic          rst_n_i,
  input  logic          tile_valid_i,
  input  tile_t         tile_i,
  input  logic          slot_freed_i,
  output logic          credit_o,
  output logic          tile_written_o,
  tile_mem_if.requester mem
);

  // wide enough to show one tile beyond the buffer
  localparam int OCC_W = $clog2(`BUF_DEPTH + 1) + 1;

  logic             pend_q;
  tile_t            tile_q;
  slot_t            wr_ptr_q;
  logic [OCC_W-1:0] occ_q;
  logic             wr_fire;

  // write the staged tile at the ring head
  assign mem.req   = pend_q;
  assign mem.we    = 1'b1;
  assign mem.addr  = wr_ptr_q;
  assign mem.wdata = tile_q;

  assign wr_fire = mem.req && mem.gnt;

  // staging register for the incoming tile
  always_ff @(posedge clk) begin
    if (tile_valid_i) begin
      tile_q <= tile_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q         <= 1'b0;
      wr_ptr_q       <= '0;
      occ_q          <= '0;
      credit_o       <= 1'b0;
      tile_written_o <= 1'b0;
    end else begin
      pend_q <= tile_valid_i;
      // tell the drain one edge after the write
      tile_written_o <= wr_fire;
      // each freed slot goes back to the host as one credit
      credit_o <= slot_freed_i;
      if (wr_fire) begin
        wr_ptr_q <= wr_ptr_q + slot_t'(1);
      end
      // tiles accepted from the host and not yet freed
      occ_q <= occ_q + OCC_W'(tile_valid_i) - OCC_W'(slot_freed_i);
    end
  end

  // ========================================================================
  // checks
  // ========================================================================

  // staged tile is lost if the write is not taken at once
  a_wr_granted: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    mem.req |-> mem.gnt
  ) else $error("tile_ingest: write not granted");

  // more tiles than slots means the host ignored its credits
  a_no_overrun: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    occ_q <= OCC_W'(`BUF_DEPTH)
  ) else $error("tile_ingest: host credit violation, occupancy %0d", occ_q);

endmodule

/* tile_drain.sv */
// ==========================================================================
// reads stored tiles in arrival order and feeds the adder tree
// a result credit is taken at read grant, so the tree never stalls
// at most one read every two cycles, reads yield to ingest writes
// ==========================================================================
`timescale 1ns/100ps
`include "reduce_config.svh"

module tile_drain import reduce_pkg::*; (
  input  logic          clk,
  input  logic          rst_n_i,
  input  logic          tile_written_i,
  input  logic          result_credit_i,
  output logic          slot_freed_o,
  output logic          tree_valid_o,
  output tile_t         tree_tile_o,
  tile_mem_if.requester mem
);

  localparam int CNT_W = $clog2(`BUF_DEPTH + 1) + 1;
  localparam int CRD_W = $clog2(`OUT_CREDITS + 1) + 1;

  drain_state_e     state_q;
  logic [CNT_W-1:0] stored_q;
  logic [CRD_W-1:0] credits_q;
  slot_t            rd_ptr_q;
  logic             have_tile;
  logic             rd_fire;

  // a tile written last edge counts already
  assign have_tile = (stored_q != '0) || tile_written_i;

  // no request in the cycle after a granted read
  assign mem.req   = (state_q == DRAIN_IDLE) && have_tile && (credits_q != '0);
  assign mem.we    = 1'b0;
  assign mem.addr  = rd_ptr_q;
  assign mem.wdata = '0;

  assign rd_fire = mem.req && mem.gnt;

  // slot is free as soon as its read is taken
  assign slot_freed_o = rd_fire;

  // buffer data is valid in the cycle after the grant
  assign tree_valid_o = (state_q == DRAIN_READ);
  assign tree_tile_o  = mem.rdata;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= DRAIN_IDLE;
      stored_q  <= '0;
      credits_q <= CRD_W'(`OUT_CREDITS);
      rd_ptr_q  <= '0;
    end else begin
      stored_q  <= stored_q + CNT_W'(tile_written_i) - CNT_W'(rd_fire);
      // spend one credit per read, regain one per consumed result
      credits_q <= credits_q + CRD_W'(result_credit_i) - CRD_W'(rd_fire);
      if (rd_fire) begin
        rd_ptr_q <= rd_ptr_q + slot_t'(1);
      end
      case (state_q)
        DRAIN_IDLE: begin
          if (rd_fire) begin
            state_q <= DRAIN_READ;
          end
        end
        // data returns here, back to idle regardless
        DRAIN_READ: state_q <= DRAIN_IDLE;
        default:    state_q <= DRAIN_IDLE;
      endcase
    end
  end

  // underflow wraps high, so one bound covers both ends
  a_credit_range: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    credits_q <= CRD_W'(`OUT_CREDITS)
  ) else $error("tile_drain: result credits out of range, %0d", credits_q);

endmodule

/* reduce_stage.sv */
// ==========================================================================
// one level of the pairwise adder tree, one cycle of latency
// sums wrap modulo 2^DW, an odd last element is added to zero
// ==========================================================================
`timescale 1ns/100ps

module reduce_stage import reduce_pkg::*; #(
  parameter int PREV_N = 2
) (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic                         valid_i,
  input  elem_t [PREV_N-1:0]           prev_i,
  output elem_t [(PREV_N+1)/2-1:0]     cur_o,
  output logic                         valid_o
);

  localparam int CUR_N = (PREV_N + 1) / 2;

  // inputs padded to an even count
  elem_t [2*CUR_N-1:0] padded;

  always_comb begin
    padded             = '0;
    padded[PREV_N-1:0] = prev_i;
  end

  // pair 2j with 2j+1, carry out of the top bit is dropped
  always_ff @(posedge clk) begin
    for (int j = 0; j < CUR_N; j++) begin
      cur_o[j] <= padded[2*j] + padded[2*j+1];
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

endmodule

/* accum_n.sv */
// ==========================================================================
// reduces each (h,p) lane of a tile over n, latency STAGES cycles
// all lanes run in lockstep, valid_o comes from lane 0
// N=1 builds no stages and passes the tile straight through
// ==========================================================================
`timescale 1ns/100ps
`include "reduce_config.svh"

module accum_n import reduce_pkg::*; (
  input  logic    clk,
  input  logic    rst_n_i,
  input  logic    valid_i,
  input  tile_t   tile_i,
  output result_t sum_o,
  output logic    valid_o
);

  localparam int LANES = `H_TILE * `P_TILE;

  // element count left after lvl levels, ceil(N / 2^lvl)
  function automatic int level_width(int lvl);
    return (`N_TILE + (1 << lvl) - 1) >> lvl;
  endfunction

  // tile viewed as elements, lane l owns slices l*N .. l*N+N-1
  elem_t [LANES*`N_TILE-1:0] elems;
  elem_t [LANES-1:0]         sums;

  assign elems = tile_i;
  assign sum_o = sums;

  if (STAGES == 0) begin : g_bypass
    // one element per lane is already the sum
    assign sums    = elems;
    assign valid_o = valid_i;
  end else begin : g_tree
    for (genvar l = 0; l < LANES; l++) begin : g_lane
      // ======================================================================
      // chain of levels, level s holds level_width(s) partial sums
      // ======================================================================
      for (genvar s = 1; s <= STAGES; s++) begin : g_lvl
        elem_t [level_width(s)-1:0] cur;
        logic                       cur_valid;

        if (s == 1) begin : g_first
          reduce_stage #(.PREV_N(`N_TILE)) u_stage (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .valid_i (valid_i),
            .prev_i  (elems[l*`N_TILE +: `N_TILE]),
            .cur_o   (cur),
            .valid_o (cur_valid)
          );
        end else begin : g_next
          reduce_stage #(.PREV_N(level_width(s-1))) u_stage (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .valid_i (g_lvl[s-1].cur_valid),
            .prev_i  (g_lvl[s-1].cur),
            .cur_o   (cur),
            .valid_o (cur_valid)
          );
        end
      end

      // last level is down to a single element
      assign sums[l] = g_lvl[STAGES].cur[0];

      // every lane runs the same chain, lane 0 stands for all
      if (l == 0) begin : g_valid
        assign valid_o = g_lvl[STAGES].cur_valid;
      end
    end
  end

endmodule

/* reduce_engine_top.sv */
// ==========================================================================
// tile reduction engine, credit flow control on both sides
// host starts with BUF_DEPTH credits, engine with OUT_CREDITS
// idle latency from tile sample to result is STAGES+2 edges
// ==========================================================================
`timescale 1ns/100ps

module reduce_engine_top import reduce_pkg::*; (
  input  logic    clk,
  input  logic    rst_n_i,
  input  logic    tile_valid_i,
  input  tile_t   tile_i,
  output logic    credit_o,
  output logic    result_valid_o,
  output result_t result_o,
  input  logic    result_credit_i
);

  // peer ports and the merged buffer port
  tile_mem_if wr_if  ();
  tile_mem_if rd_if  ();
  tile_mem_if buf_if ();

  // peer handshakes
  logic  tile_written;
  logic  slot_freed;
  // drain to tree
  logic  tree_valid;
  tile_t tree_tile;

  tile_ingest u_ingest (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .tile_valid_i   (tile_valid_i),
    .tile_i         (tile_i),
    .slot_freed_i   (slot_freed),
    .credit_o       (credit_o),
    .tile_written_o (tile_written),
    .mem            (wr_if.requester)
  );

  tile_drain u_drain (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .tile_written_i  (tile_written),
    .result_credit_i (result_credit_i),
    .slot_freed_o    (slot_freed),
    .tree_valid_o    (tree_valid),
    .tree_tile_o     (tree_tile),
    .mem             (rd_if.requester)
  );

  mem_arbiter u_arb (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .wr_port (wr_if.arbiter),
    .rd_port (rd_if.arbiter),
    .mem     (buf_if.requester)
  );

  tile_buffer u_buf (
    .clk (clk),
    .mem (buf_if.arbiter)
  );

  accum_n u_accum (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .valid_i (tree_valid),
    .tile_i  (tree_tile),
    .sum_o   (result_o),
    .valid_o (result_valid_o)
  );

endmodule

/* tb_reduce_engine.sv */
// ==========================================================================
// testbench for the tile reduction engine, one build-time tile shape
// host and result credits are modelled here, expected sums wrap modulo 2^DW
// random tiles come from $urandom with a fixed seed, a watchdog bounds the run
// ==========================================================================
`timescale 1ns/100ps
`include "reduce_config.svh"

module tb_reduce_engine import reduce_pkg::*; ();

  localparam int LANES     = `H_TILE * `P_TILE;
  // tiles over the whole run, 1 + 40 + 4 + 6
  localparam int NUM_TILES = 51;
  localparam int WATCHDOG  = NUM_TILES * 20 + 500;

  logic    clk = 1'b0;
  logic    rst_n_i;
  logic    tile_valid_i;
  tile_t   tile_i;
  logic    credit_o;
  logic    result_valid_o;
  result_t result_o;
  logic    result_credit_i = 1'b0;
  // consumer hands result credits straight back while set
  logic    return_en = 1'b1;

  // expected sums in send order, read back in arrival order
  result_t exp_mem [NUM_TILES];
  string   test_name = "reset_state";
  int      tiles_sent = 0;
  int      credits_back = 0;
  int      results_seen = 0;
  int      credits_returned = 0;
  int      host_credits;
  int      held;
  // failure counts, each written by a single process
  int      mon_errors = 0;
  int      seq_errors = 0;
  int      quiet_fails = 0;
  int      range_fails = 0;
  int      hold_fails = 0;
  int      tests_run = 0;
  int      tests_failed = 0;

  // host side credits and results held by the consumer
  assign host_credits = `BUF_DEPTH - tiles_sent + credits_back;
  assign held         = results_seen - credits_returned;

  reduce_engine_top dut0 (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .tile_valid_i    (tile_valid_i),
    .tile_i          (tile_i),
    .credit_o        (credit_o),
    .result_valid_o  (result_valid_o),
    .result_o        (result_o),
    .result_credit_i (result_credit_i)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  // ========================================================================
  // reference model and stimulus helpers
  // ========================================================================

  // lane l = h*P+p holds elements l*N .. l*N+N-1, summed in plain order
  function automatic result_t lane_sums(input tile_t t);
    result_t res;
    elem_t   acc;
    res = '0;
    for (int l = 0; l < LANES; l++) begin
      acc = '0;
      for (int n = 0; n < `N_TILE; n++) begin
        acc = acc + t[(l * `N_TILE + n) * `DW +: `DW];
      end
      res[l * `DW +: `DW] = acc;
    end
    return res;
  endfunction

  // pairwise levels needed to bring n elements down to one
  function automatic int tree_depth(input int n);
    int d;
    d = 0;
    while ((1 << d) < n) begin
      d++;
    end
    return d;
  endfunction

  function automatic tile_t random_tile();
    tile_t t;
    for (int i = 0; i < $bits(tile_t) / 32; i++) begin
      t[i * 32 +: 32] = $urandom();
    end
    return t;
  endfunction

  // a at even n, b at odd n, in every lane
  function automatic tile_t pattern_tile(input elem_t a, input elem_t b);
    tile_t t;
    for (int i = 0; i < LANES * `N_TILE; i++) begin
      t[i * `DW +: `DW] = (i % 2 == 0) ? a : b;
    end
    return t;
  endfunction

  function automatic tile_t set_elem(input tile_t t, input int lane, input int n,
                                     input elem_t v);
    tile_t r;
    r = t;
    r[(lane * `N_TILE + n) * `DW +: `DW] = v;
    return r;
  endfunction

  function automatic int total_errors();
    return mon_errors + seq_errors + quiet_fails + range_fails + hold_fails;
  endfunction

  // drives one tile on the next edge where the host holds a credit
  task automatic send_tile(input tile_t t);
    @(posedge clk);
    while (host_credits == 0) begin
      tile_valid_i <= 1'b0;
      @(posedge clk);
    end
    tile_valid_i <= 1'b1;
    tile_i       <= t;
    exp_mem[tiles_sent] = lane_sums(t);
    tiles_sent++;
  endtask

  task automatic end_burst();
    @(posedge clk);
    tile_valid_i <= 1'b0;
  endtask

  // all results back, all credits home, bounded by max_cycles
  task automatic wait_idle(input int max_cycles);
    int cyc = 0;
    while (!(results_seen == tiles_sent && held == 0 && host_credits == `BUF_DEPTH)
           && cyc < max_cycles) begin
      @(negedge clk);
      cyc++;
    end
    if (!(results_seen == tiles_sent && held == 0 && host_credits == `BUF_DEPTH)) begin
      seq_errors++;
      $display("test %s: engine did not drain, %0d of %0d results seen",
               test_name, results_seen, tiles_sent);
    end
    // returned credit still has to reach the drain
    repeat (3) @(posedge clk);
  endtask

  task automatic finish_test(input int errs_before);
    tests_run++;
    if (total_errors() == errs_before) begin
      $display("test %-14s ok", test_name);
    end else begin
      tests_failed++;
      $display("test %-14s FAILED, %0d errors", test_name, total_errors() - errs_before);
    end
  endtask

  // ========================================================================
  // result port monitor and consumer
  // ========================================================================

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    result_t exp_sum;
    if (rst_n_i) begin
      if (credit_o) begin
        credits_back++;
      end
      if (result_valid_o) begin
        if (results_seen >= tiles_sent) begin
          mon_errors++;
          $display("test %s: result %h with no tile outstanding", test_name, result_o);
        end else begin
          exp_sum = exp_mem[results_seen];
          a_result_value: assert (result_o == exp_sum) else begin
            mon_errors++;
            $display("mismatch %s: result %0d expected %h actual %h",
                     test_name, results_seen, exp_sum, result_o);
          end
        end
        results_seen++;
      end
    end
  end

  // one credit pulse per held result while returns are enabled
  always @(posedge clk) begin
    if (rst_n_i && return_en && held > 0) begin
      result_credit_i  <= 1'b1;
      credits_returned <= credits_returned + 1;
    end else begin
      result_credit_i <= 1'b0;
    end
  end

  a_quiet_reset: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (tiles_sent == 0) |-> (!credit_o && !result_valid_o)
  ) else begin
    quiet_fails++;
    $display("test %s: credit_o or result_valid_o high before any tile", test_name);
  end

  a_host_credit_range: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    host_credits >= 0 && host_credits <= `BUF_DEPTH
  ) else begin
    range_fails++;
    $display("test %s: host credit count out of range, %0d", test_name, host_credits);
  end

  // never more results in flight to the consumer than result credits
  a_result_hold: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    held >= 0 && held <= `OUT_CREDITS
  ) else begin
    hold_fails++;
    $display("test %s: %0d results held beyond the result credits", test_name, held);
  end

  // ========================================================================
  // test sequence
  // ========================================================================

  initial begin
    int errs;
    int lat;
    int lat_exp;
    int seen0;
    int back0;
    void'($urandom(32'hf69a));
    rst_n_i      = 1'b0;
    tile_valid_i = 1'b0;
    tile_i       = '0;
    // tree levels plus the write edge and the read edge
    lat_exp      = tree_depth(`N_TILE) + 2;
    repeat (3) @(posedge clk);
    rst_n_i <= 1'b1;

    // idle engine must stay quiet
    errs = total_errors();
    repeat (8) @(posedge clk);
    finish_test(errs);

    test_name = "latency";
    errs = total_errors();
    send_tile(random_tile());
    // this edge samples the tile
    end_burst();
    lat = 0;
    @(negedge clk);
    while (!result_valid_o && lat < 4 * lat_exp + 10) begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end
    a_latency: assert (lat == lat_exp) else begin
      seq_errors++;
      $display("mismatch %s: edges expected %0d actual %0d", test_name, lat_exp, lat);
    end
    wait_idle(100);
    finish_test(errs);

    test_name = "random_stream";
    errs = total_errors();
    for (int i = 0; i < 40; i++) begin
      send_tile(random_tile());
    end
    end_burst();
    wait_idle(400);
    finish_test(errs);

    // all ones, signed extremes, and a changed last element in the top lane
    test_name = "wraparound";
    errs = total_errors();
    send_tile(pattern_tile(16'hffff, 16'hffff));
    send_tile(pattern_tile(16'h7fff, 16'h8000));
    send_tile(pattern_tile(16'h8000, 16'h0001));
    send_tile(set_elem(pattern_tile(16'hffff, 16'h0001), LANES - 1, `N_TILE - 1, 16'h7fff));
    end_burst();
    wait_idle(200);
    finish_test(errs);

    test_name = "backpressure";
    errs = total_errors();
    return_en <= 1'b0;
    seen0 = results_seen;
    for (int i = 0; i < `OUT_CREDITS + `BUF_DEPTH; i++) begin
      send_tile(random_tile());
    end
    end_burst();
    back0 = credits_back;
    repeat (30) @(posedge clk);
    a_bp_results: assert (results_seen - seen0 == `OUT_CREDITS) else begin
      seq_errors++;
      $display("mismatch %s: results expected %0d actual %0d",
               test_name, `OUT_CREDITS, results_seen - seen0);
    end
    a_bp_stall: assert (credits_back == back0 && host_credits == 0) else begin
      seq_errors++;
      $display("test %s: host credits kept coming back with the buffer full", test_name);
    end
    return_en <= 1'b1;
    wait_idle(300);
    finish_test(errs);

    test_name = "credit_balance";
    errs = total_errors();
    a_credits_home: assert (host_credits == `BUF_DEPTH) else begin
      seq_errors++;
      $display("mismatch %s: host credits expected %0d actual %0d",
               test_name, `BUF_DEPTH, host_credits);
    end
    finish_test(errs);

    $display("tests %0d, failed %0d, tiles %0d, results %0d, errors %0d",
             tests_run, tests_failed, tiles_sent, results_seen, total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // bound on the whole run, scaled by the tile count
  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("watchdog: run exceeded %0d cycles in test %s", WATCHDOG, test_name);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* files.f */
+incdir+.
reduce_pkg.sv
tile_mem_if.sv
tile_buffer.sv
mem_arbiter.sv
tile_ingest.sv
tile_drain.sv
reduce_stage.sv
accum_n.sv
reduce_engine_top.sv
tb_reduce_engine.sv

/* run_sim.sh */
#!/bin/sh
# build and run the tile reduction engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f files.f --top-module tb_reduce_engine -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1
